/* ex_macros.svh */
// width and step-count macros shared by the execute-stage packages and modules
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data and address width
`define XLEN 32

// result tag width
`define TAG_W 4

// one shift-add step per multiplier bit
`define MULT_STEPS `XLEN

`endif

/* ex_op_pkg.sv */
// opcode, multiplier state and issued-operation types for the execute stage and its units
`default_nettype none

`include "ex_macros.svh"

package ex_op_pkg;

    // opcodes as seen on the issue port
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_BEQ,
        OP_BNE,
        OP_MUL,
        OP_LW,
        OP_SW
    } ex_op_e;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_RUN,
        MS_DONE
    } mult_state_e;

    // one operation handed to a unit
    typedef struct packed {
        ex_op_e             op;
        logic [`XLEN-1:0]   a;
        logic [`XLEN-1:0]   b;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
        logic [`TAG_W-1:0]  tag;
    } fu_in_t;

endpackage

`default_nettype wire

/* ex_result_pkg.sv */
// completed-result and broadcast-source types used by the units, the stage and the checker
`default_nettype none

`include "ex_macros.svh"

package ex_result_pkg;

    // a finished result held by a unit until broadcast
    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        logic [`XLEN-1:0]   value;
        logic               take_branch;
    } fu_out_t;

    // which unit owns the common data bus this cycle
    typedef enum logic [1:0] {
        U_ALU,
        U_MULT,
        U_MEM
    } unit_sel_e;

endpackage

`default_nettype wire

/* fu_if.sv */
// link between the stage and one functional unit, carrying issue in and the held result out
`timescale 1ns/1ps
`default_nettype none

interface fu_if;

    // stage to unit
    logic                   issue;
    ex_op_pkg::fu_in_t      op_in;
    logic                   ack;

    // unit to stage with the result held while valid
    ex_result_pkg::fu_out_t result;
    logic                   busy;

    modport unit (
        input  issue, op_in, ack,
        output result, busy
    );

    modport stage (
        output issue, op_in, ack,
        input  result, busy
    );

endinterface

`default_nettype wire

/* alu_fu.sv */
// single-cycle integer and branch unit, holds its result until the stage acknowledges it
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module alu_fu (
    input  logic clock,
    input  logic reset,
    fu_if.unit   fu
);

    ex_result_pkg::fu_out_t res_d;
    ex_result_pkg::fu_out_t res_q;
    logic                   taken;

    always_comb begin
        res_d       = '0;
        res_d.valid = 1'b1;
        res_d.tag   = fu.op_in.tag;
        taken       = 1'b0;
        case (fu.op_in.op)
            ex_op_pkg::OP_ADD: res_d.value = fu.op_in.a + fu.op_in.b;
            ex_op_pkg::OP_SUB: res_d.value = fu.op_in.a - fu.op_in.b;
            ex_op_pkg::OP_AND: res_d.value = fu.op_in.a & fu.op_in.b;
            ex_op_pkg::OP_OR:  res_d.value = fu.op_in.a | fu.op_in.b;
            ex_op_pkg::OP_XOR: res_d.value = fu.op_in.a ^ fu.op_in.b;
            ex_op_pkg::OP_SLT: begin
                // signed compare
                res_d.value = {{(`XLEN-1){1'b0}},
                               ($signed(fu.op_in.a) < $signed(fu.op_in.b))};
            end
            ex_op_pkg::OP_BEQ,
            ex_op_pkg::OP_BNE: begin
                taken = (fu.op_in.op == ex_op_pkg::OP_BEQ) ? (fu.op_in.a == fu.op_in.b)
                                                           : (fu.op_in.a != fu.op_in.b);
                // target when taken, fall-through otherwise
                res_d.value = taken ? (fu.op_in.pc + fu.op_in.imm)
                                    : (fu.op_in.pc + `XLEN'(4));
            end
            default: res_d.value = '0;
        endcase
        res_d.take_branch = taken;
    end

    // the whole result loads on issue and its valid bit drops on ack
    always_ff @(posedge clock) begin
        if (reset) begin
            res_q.valid <= 1'b0;
        end else if (fu.issue) begin
            res_q <= res_d;
        end else if (fu.ack) begin
            res_q.valid <= 1'b0;
        end
    end

    assign fu.result = res_q;
    assign fu.busy   = res_q.valid;

endmodule

`default_nettype wire

/* mult_ctrl.sv */
// multiplier sequencer stepping through idle, running and done with start and step strobes
`timescale 1ns/1ps
`default_nettype none

module mult_ctrl (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    issue,
    input  logic                    ack,
    input  logic                    last_step,
    output ex_op_pkg::mult_state_e  state,
    output logic                    start,
    output logic                    step,
    output logic                    busy
);

    ex_op_pkg::mult_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            ex_op_pkg::MS_IDLE: if (issue)     next_state = ex_op_pkg::MS_RUN;
            ex_op_pkg::MS_RUN:  if (last_step) next_state = ex_op_pkg::MS_DONE;
            ex_op_pkg::MS_DONE: if (ack)       next_state = ex_op_pkg::MS_IDLE;
            default:                           next_state = ex_op_pkg::MS_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ex_op_pkg::MS_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign start = issue && (state == ex_op_pkg::MS_IDLE);
    assign step  = (state == ex_op_pkg::MS_RUN);
    // busy covers the run and the wait for broadcast
    assign busy  = (state != ex_op_pkg::MS_IDLE);

endmodule

`default_nettype wire

/* step_timer.sv */
// down-counter for the multiplier, loaded at start and flagging the final shift-add step
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module step_timer (
    input  logic clock,
    input  logic reset,
    input  logic load,
    input  logic step,
    output logic last_step
);

    logic [$clog2(`MULT_STEPS)-1:0] count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= ($clog2(`MULT_STEPS))'(`MULT_STEPS - 1);
        end else if (step && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    assign last_step = (count == '0);

endmodule

`default_nettype wire

/* mult_fu.sv */
// iterative shift-add multiplier unit keeping the low word of the product
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module mult_fu (
    input  logic clock,
    input  logic reset,
    fu_if.unit   fu
);

    ex_op_pkg::mult_state_e state;
    logic                   start;
    logic                   step;
    logic                   last_step;
    logic [`XLEN-1:0]       mcand;
    logic [`XLEN-1:0]       mplier;
    logic [`XLEN-1:0]       prod;
    logic [`TAG_W-1:0]      tag_q;

    mult_ctrl ctrl0 (
        .clock     (clock),
        .reset     (reset),
        .issue     (fu.issue),
        .ack       (fu.ack),
        .last_step (last_step),
        .state     (state),
        .start     (start),
        .step      (step),
        .busy      (fu.busy)
    );

    step_timer timer0 (
        .clock     (clock),
        .reset     (reset),
        .load      (start),
        .step      (step),
        .last_step (last_step)
    );

    always_ff @(posedge clock) begin
        if (start) begin
            mcand  <= fu.op_in.a;
            mplier <= fu.op_in.b;
            prod   <= '0;
            tag_q  <= fu.op_in.tag;
        end else if (step) begin
            // add shifted multiplicand when low multiplier bit is set
            if (mplier[0]) begin
                prod <= prod + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign fu.result = '{valid:       (state == ex_op_pkg::MS_DONE),
                         tag:         tag_q,
                         value:       prod,
                         take_branch: 1'b0};

endmodule

`default_nettype wire

/* mem_fu.sv */
// load/store unit with one registered access cycle on the data-memory port
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module mem_fu (
    input  logic              clock,
    input  logic              reset,
    fu_if.unit                fu,
    input  logic [`XLEN-1:0]  dmem_rdata,
    output logic [`XLEN-1:0]  dmem_addr,
    output logic [`XLEN-1:0]  dmem_wdata,
    output logic              dmem_read,
    output logic              dmem_write
);

    logic               acc_q;
    logic               valid_q;
    logic               is_store_q;
    logic [`XLEN-1:0]   addr_q;
    logic [`XLEN-1:0]   wdata_q;
    logic [`XLEN-1:0]   value_q;
    logic [`TAG_W-1:0]  tag_q;

    // access runs the cycle after issue and the result follows a cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            acc_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            acc_q <= fu.issue;
            if (acc_q) begin
                valid_q <= 1'b1;
            end else if (fu.ack) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fu.issue) begin
            addr_q     <= fu.op_in.a + fu.op_in.imm;
            wdata_q    <= fu.op_in.b;
            is_store_q <= (fu.op_in.op == ex_op_pkg::OP_SW);
            tag_q      <= fu.op_in.tag;
        end
        // loads take the memory answer in the access cycle and stores report zero
        if (acc_q) begin
            value_q <= is_store_q ? '0 : dmem_rdata;
        end
    end

    assign dmem_addr  = addr_q;
    assign dmem_wdata = wdata_q;
    assign dmem_read  = acc_q && !is_store_q;
    assign dmem_write = acc_q && is_store_q;

    assign fu.result = '{valid: valid_q, tag: tag_q, value: value_q, take_branch: 1'b0};
    assign fu.busy   = acc_q || valid_q;

endmodule

`default_nettype wire

/* ex.sv */
// execute stage top that routes issue by opcode, broadcasts one result per cycle and reports branches
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  ex_op_pkg::ex_op_e        issue_op,
    input  logic [`XLEN-1:0]         issue_a,
    input  logic [`XLEN-1:0]         issue_b,
    input  logic [`XLEN-1:0]         issue_imm,
    input  logic [`XLEN-1:0]         issue_pc,
    input  logic [`TAG_W-1:0]        issue_tag,
    input  logic [`XLEN-1:0]         dmem_rdata,
    output logic                     alu_busy,
    output logic                     mult_busy,
    output logic                     mem_busy,
    output logic                     cdb_valid,
    output logic [`TAG_W-1:0]        cdb_tag,
    output logic [`XLEN-1:0]         cdb_value,
    output ex_result_pkg::unit_sel_e cdb_unit,
    output logic                     branch_valid,
    output logic [`TAG_W-1:0]        branch_tag,
    output logic [`XLEN-1:0]         branch_pc,
    output logic [`XLEN-1:0]         dmem_addr,
    output logic [`XLEN-1:0]         dmem_wdata,
    output logic                     dmem_read,
    output logic                     dmem_write
);

    fu_if alu_if ();
    fu_if mult_if ();
    fu_if mem_if ();

    ex_op_pkg::fu_in_t issue_pkt;
    logic              is_alu;
    logic              is_mult;
    logic              is_mem;

    assign issue_pkt = '{op: issue_op, a: issue_a, b: issue_b, imm: issue_imm,
                         pc: issue_pc, tag: issue_tag};

    // opcode class decode
    always_comb begin
        is_alu  = 1'b0;
        is_mult = 1'b0;
        is_mem  = 1'b0;
        case (issue_op)
            ex_op_pkg::OP_MUL:                    is_mult = 1'b1;
            ex_op_pkg::OP_LW, ex_op_pkg::OP_SW:   is_mem  = 1'b1;
            ex_op_pkg::OP_ADD, ex_op_pkg::OP_SUB,
            ex_op_pkg::OP_AND, ex_op_pkg::OP_OR,
            ex_op_pkg::OP_XOR, ex_op_pkg::OP_SLT,
            ex_op_pkg::OP_BEQ, ex_op_pkg::OP_BNE: is_alu  = 1'b1;
            default:                              is_alu  = 1'b0;
        endcase
    end

    // a busy unit never takes a new operation
    assign alu_if.issue  = issue_valid && is_alu && !alu_if.busy;
    assign mult_if.issue = issue_valid && is_mult && !mult_if.busy;
    assign mem_if.issue  = issue_valid && is_mem && !mem_if.busy;
    assign alu_if.op_in  = issue_pkt;
    assign mult_if.op_in = issue_pkt;
    assign mem_if.op_in  = issue_pkt;

    assign alu_busy  = alu_if.busy;
    assign mult_busy = mult_if.busy;
    assign mem_busy  = mem_if.busy;

    // fixed priority with alu over multiplier over memory
    always_comb begin
        cdb_valid    = 1'b0;
        cdb_tag      = '0;
        cdb_value    = '0;
        cdb_unit     = ex_result_pkg::U_ALU;
        alu_if.ack   = 1'b0;
        mult_if.ack  = 1'b0;
        mem_if.ack   = 1'b0;
        if (alu_if.result.valid) begin
            cdb_valid  = 1'b1;
            cdb_tag    = alu_if.result.tag;
            cdb_value  = alu_if.result.value;
            alu_if.ack = 1'b1;
        end else if (mult_if.result.valid) begin
            cdb_valid   = 1'b1;
            cdb_tag     = mult_if.result.tag;
            cdb_value   = mult_if.result.value;
            cdb_unit    = ex_result_pkg::U_MULT;
            mult_if.ack = 1'b1;
        end else if (mem_if.result.valid) begin
            cdb_valid  = 1'b1;
            cdb_tag    = mem_if.result.tag;
            cdb_value  = mem_if.result.value;
            cdb_unit   = ex_result_pkg::U_MEM;
            mem_if.ack = 1'b1;
        end
    end

    // only the alu resolves branches
    assign branch_valid = alu_if.ack && alu_if.result.take_branch;
    assign branch_tag   = alu_if.result.tag;
    assign branch_pc    = alu_if.result.value;

    alu_fu alu0 (
        .clock (clock),
        .reset (reset),
        .fu    (alu_if)
    );

    mult_fu mult0 (
        .clock (clock),
        .reset (reset),
        .fu    (mult_if)
    );

    mem_fu mem0 (
        .clock      (clock),
        .reset      (reset),
        .fu         (mem_if),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write)
    );

endmodule

`default_nettype wire

/* ex_checker.sv */
// protocol assertions for the execute stage, attached to ex by a bind in the testbench
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
    input logic                     clock,
    input logic                     reset,
    input logic                     cdb_valid,
    input ex_result_pkg::unit_sel_e cdb_unit,
    input logic                     branch_valid,
    input logic                     dmem_read,
    input logic                     dmem_write,
    input logic                     alu_valid,
    input logic                     mult_valid,
    input logic                     mem_valid,
    input logic                     alu_ack,
    input logic                     mult_ack,
    input logic                     mem_ack
);

    // violations so far
    int fail_count = 0;

    quiet_after_reset: assert property (@(posedge clock)
        reset |=> !cdb_valid && !branch_valid && !dmem_read && !dmem_write)
        else begin
            $error("broadcast, branch port or memory strobe active during reset");
            fail_count = fail_count + 1;
        end

    // one ack at a time, and only to a unit holding a result
    ack_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0({alu_ack, mult_ack, mem_ack})
        && (!alu_ack || alu_valid) && (!mult_ack || mult_valid) && (!mem_ack || mem_valid))
        else begin
            $error("ack not one-hot or given without a held result");
            fail_count = fail_count + 1;
        end

    // alu first, then multiplier, then memory
    cdb_priority: assert property (@(posedge clock) disable iff (reset)
        (cdb_valid == (alu_valid || mult_valid || mem_valid))
        && (!cdb_valid || cdb_unit == (alu_valid ? ex_result_pkg::U_ALU :
                                       mult_valid ? ex_result_pkg::U_MULT :
                                                    ex_result_pkg::U_MEM)))
        else begin
            $error("broadcast source breaks fixed priority");
            fail_count = fail_count + 1;
        end

    branch_from_alu: assert property (@(posedge clock) disable iff (reset)
        branch_valid |-> cdb_valid && cdb_unit == ex_result_pkg::U_ALU)
        else begin
            $error("branch port active without an alu broadcast");
            fail_count = fail_count + 1;
        end

    // a memory access lasts exactly one cycle
    strobe_single: assert property (@(posedge clock) disable iff (reset)
        (dmem_read || dmem_write) |-> !(dmem_read && dmem_write)
        ##1 !(dmem_read || dmem_write))
        else begin
            $error("memory strobe longer than one cycle or read and write together");
            fail_count = fail_count + 1;
        end

endmodule

`default_nettype wire

/* ex_tb.sv */
// testbench for the execute stage with directed and random issue checked against a tag scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "ex_macros.svh"

module ex_tb;

    localparam int DIRECTED_OPS = 16;
    localparam int RANDOM_OPS   = 200;
    localparam int TAGS         = 2 ** `TAG_W;

    logic                     clock;
    logic                     reset;
    logic                     issue_valid;
    ex_op_pkg::ex_op_e        issue_op;
    logic [`XLEN-1:0]         issue_a;
    logic [`XLEN-1:0]         issue_b;
    logic [`XLEN-1:0]         issue_imm;
    logic [`XLEN-1:0]         issue_pc;
    logic [`TAG_W-1:0]        issue_tag;
    logic [`XLEN-1:0]         dmem_rdata;
    logic                     alu_busy;
    logic                     mult_busy;
    logic                     mem_busy;
    logic                     cdb_valid;
    logic [`TAG_W-1:0]        cdb_tag;
    logic [`XLEN-1:0]         cdb_value;
    ex_result_pkg::unit_sel_e cdb_unit;
    logic                     branch_valid;
    logic [`TAG_W-1:0]        branch_tag;
    logic [`XLEN-1:0]         branch_pc;
    logic [`XLEN-1:0]         dmem_addr;
    logic [`XLEN-1:0]         dmem_wdata;
    logic                     dmem_read;
    logic                     dmem_write;

    // memory model and its scoreboard copy
    logic [`XLEN-1:0]         mem [0:63];
    logic [`XLEN-1:0]         mirror [0:63];

    // expected results per tag
    logic [`XLEN-1:0]         exp_value [0:TAGS-1];
    logic                     exp_taken [0:TAGS-1];
    ex_result_pkg::unit_sel_e exp_unit [0:TAGS-1];
    logic                     pending [0:TAGS-1];
    int                       issue_cycle [0:TAGS-1];
    int                       bcast_cycle [0:TAGS-1];
    int                       cycle;
    int                       outstanding;
    logic [`TAG_W-1:0]        next_tag;
    logic                     exact_latency;

    // memory strobe cycles seen against accesses issued
    int                       reads_seen;
    int                       writes_seen;
    int                       loads_sent;
    int                       stores_sent;

    ex dut0 (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_imm    (issue_imm),
        .issue_pc     (issue_pc),
        .issue_tag    (issue_tag),
        .dmem_rdata   (dmem_rdata),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .mem_busy     (mem_busy),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .cdb_unit     (cdb_unit),
        .branch_valid (branch_valid),
        .branch_tag   (branch_tag),
        .branch_pc    (branch_pc),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write)
    );

    bind ex ex_checker chk0 (
        .clock        (clock),
        .reset        (reset),
        .cdb_valid    (cdb_valid),
        .cdb_unit     (cdb_unit),
        .branch_valid (branch_valid),
        .dmem_read    (dmem_read),
        .dmem_write   (dmem_write),
        .alu_valid    (alu_if.result.valid),
        .mult_valid   (mult_if.result.valid),
        .mem_valid    (mem_if.result.valid),
        .alu_ack      (alu_if.ack),
        .mult_ack     (mult_if.ack),
        .mem_ack      (mem_if.ack)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    // word-addressed memory answering in the same cycle
    assign dmem_rdata = mem[dmem_addr[5:0]];
    always @(posedge clock) begin
        if (dmem_write) begin
            mem[dmem_addr[5:0]] <= dmem_wdata;
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic ex_result_pkg::unit_sel_e unit_of(input ex_op_pkg::ex_op_e op);
        case (op)
            ex_op_pkg::OP_MUL:                  return ex_result_pkg::U_MULT;
            ex_op_pkg::OP_LW, ex_op_pkg::OP_SW: return ex_result_pkg::U_MEM;
            default:                            return ex_result_pkg::U_ALU;
        endcase
    endfunction

    function automatic logic unit_busy(input ex_result_pkg::unit_sel_e u);
        case (u)
            ex_result_pkg::U_MULT: return mult_busy;
            ex_result_pkg::U_MEM:  return mem_busy;
            default:               return alu_busy;
        endcase
    endfunction

    function automatic int base_latency(input ex_result_pkg::unit_sel_e u);
        case (u)
            ex_result_pkg::U_MULT: return `MULT_STEPS + 1;
            ex_result_pkg::U_MEM:  return 2;
            default:               return 1;
        endcase
    endfunction

    // drive one issue for a cycle and record what it must produce
    task automatic send(input ex_op_pkg::ex_op_e op, input logic [`XLEN-1:0] a, b, imm, pc);
        logic [`XLEN-1:0] v;
        logic             tk;
        logic [5:0]       idx;
        tk  = 1'b0;
        idx = a[5:0] + imm[5:0];
        case (op)
            ex_op_pkg::OP_ADD: v = a + b;
            ex_op_pkg::OP_SUB: v = a - b;
            ex_op_pkg::OP_AND: v = a & b;
            ex_op_pkg::OP_OR:  v = a | b;
            ex_op_pkg::OP_XOR: v = a ^ b;
            ex_op_pkg::OP_SLT: v = ($signed(a) < $signed(b)) ? 1 : 0;
            ex_op_pkg::OP_BEQ, ex_op_pkg::OP_BNE: begin
                tk = (op == ex_op_pkg::OP_BEQ) ? (a == b) : (a != b);
                v  = tk ? pc + imm : pc + 32'd4;
            end
            ex_op_pkg::OP_MUL: v = a * b;
            ex_op_pkg::OP_LW: begin
                v          = mirror[idx];
                loads_sent = loads_sent + 1;
            end
            default: begin
                v           = '0;
                mirror[idx] = b;
                stores_sent = stores_sent + 1;
            end
        endcase
        exp_value[next_tag]   = v;
        exp_taken[next_tag]   = tk;
        exp_unit[next_tag]    = unit_of(op);
        pending[next_tag]     = 1'b1;
        issue_cycle[next_tag] = cycle + 1;
        outstanding           = outstanding + 1;
        issue_valid = 1'b1;
        issue_op    = op;
        issue_a     = a;
        issue_b     = b;
        issue_imm   = imm;
        issue_pc    = pc;
        issue_tag   = next_tag;
        next_tag    = next_tag + 1'b1;
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (outstanding != 0) begin
            @(negedge clock);
        end
    endtask

    task automatic send_and_drain(input ex_op_pkg::ex_op_e op,
                                  input logic [`XLEN-1:0] a, b, imm, pc);
        send(op, a, b, imm, pc);
        wait_idle();
    endtask

    // scoreboard compares each broadcast at the edge that consumes it
    always @(posedge clock) begin
        int lat;
        cycle = cycle + 1;
        if (!reset && dmem_read) begin
            reads_seen = reads_seen + 1;
        end
        if (!reset && dmem_write) begin
            writes_seen = writes_seen + 1;
        end
        if (!reset && cdb_valid) begin
            lat = cycle - issue_cycle[cdb_tag];
            assert (pending[cdb_tag])
                else stop_run($sformatf("Mismatch at %0t: tag %0d not in flight", $time, cdb_tag));
            assert (cdb_value == exp_value[cdb_tag] && cdb_unit == exp_unit[cdb_tag])
                else stop_run($sformatf(
                    "Mismatch at %0t: tag %0d value %h unit %0d, expected %h %0d",
                    $time, cdb_tag, cdb_value, cdb_unit, exp_value[cdb_tag], exp_unit[cdb_tag]));
            assert (branch_valid == exp_taken[cdb_tag]
                    && (!branch_valid || (branch_tag == cdb_tag && branch_pc == exp_value[cdb_tag])))
                else stop_run($sformatf("Mismatch at %0t: branch port wrong for tag %0d",
                    $time, cdb_tag));
            assert (exact_latency ? lat == base_latency(exp_unit[cdb_tag])
                                  : lat >= base_latency(exp_unit[cdb_tag]))
                else stop_run($sformatf("Mismatch at %0t: tag %0d latency %0d", $time, cdb_tag, lat));
            // each access strobes its port for one cycle before its result goes out
            assert (exp_unit[cdb_tag] != ex_result_pkg::U_MEM
                    || (reads_seen == loads_sent && writes_seen == stores_sent))
                else stop_run($sformatf(
                    "Mismatch at %0t: tag %0d saw %0d reads %0d writes, expected %0d %0d",
                    $time, cdb_tag, reads_seen, writes_seen, loads_sent, stores_sent));
            pending[cdb_tag]     = 1'b0;
            bcast_cycle[cdb_tag] = cycle;
            outstanding          = outstanding - 1;
        end else if (!reset) begin
            assert (!branch_valid)
                else stop_run($sformatf("Mismatch at %0t: branch_valid without broadcast", $time));
        end
    end

    always @(negedge clock) begin
        if (dut0.chk0.fail_count != 0) begin
            stop_run("protocol checker bound into the stage reported a violation");
        end
    end

    initial begin
        repeat ((DIRECTED_OPS + RANDOM_OPS) * 40 + 100) @(posedge clock);
        stop_run("watchdog expired before all operations were broadcast");
    end

    initial begin
        integer            seed;
        logic [31:0]       pick;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        ex_op_pkg::ex_op_e op;
        int                sent;
        logic [`TAG_W-1:0] t_mul;
        logic [`TAG_W-1:0] t_mem;
        logic [`TAG_W-1:0] t_alu;
        seed          = 32'h26f4;
        reset         = 1'b1;
        issue_valid   = 1'b0;
        issue_op      = ex_op_pkg::OP_ADD;
        issue_a       = '0;
        issue_b       = '0;
        issue_imm     = '0;
        issue_pc      = '0;
        issue_tag     = '0;
        cycle         = 0;
        outstanding   = 0;
        next_tag      = '0;
        exact_latency = 1'b1;
        reads_seen    = 0;
        writes_seen   = 0;
        loads_sent    = 0;
        stores_sent   = 0;
        for (int i = 0; i < 64; i++) begin
            mem[i]    = i * 3;
            mirror[i] = i * 3;
        end
        for (int i = 0; i < TAGS; i++) begin
            pending[i] = 1'b0;
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (!alu_busy && !mult_busy && !mem_busy && !cdb_valid && !branch_valid
                && !dmem_read && !dmem_write)
            else stop_run($sformatf("Mismatch at %0t: stage not idle after reset", $time));

        // each alu opcode alone with branches taken and not taken
        send_and_drain(ex_op_pkg::OP_ADD, 32'd1234, 32'd4321, '0, 32'h100);
        send_and_drain(ex_op_pkg::OP_SUB, 32'd10, 32'd25, '0, 32'h104);
        send_and_drain(ex_op_pkg::OP_AND, 32'hf0f0_1234, 32'h0ff0_ffff, '0, 32'h108);
        send_and_drain(ex_op_pkg::OP_OR, 32'h1200_0034, 32'h0056_7800, '0, 32'h10c);
        send_and_drain(ex_op_pkg::OP_XOR, 32'haaaa_5555, 32'hffff_0000, '0, 32'h110);
        send_and_drain(ex_op_pkg::OP_SLT, 32'hffff_fffb, 32'd3, '0, 32'h114);
        send_and_drain(ex_op_pkg::OP_BEQ, 32'd7, 32'd7, 32'h40, 32'h200);
        send_and_drain(ex_op_pkg::OP_BEQ, 32'd7, 32'd8, 32'h40, 32'h204);
        send_and_drain(ex_op_pkg::OP_BNE, 32'd1, 32'd2, 32'hffff_fff0, 32'h300);
        send_and_drain(ex_op_pkg::OP_BNE, 32'd5, 32'd5, 32'h20, 32'h304);

        // lone multiply keeps mult_busy high until broadcast
        a = $random(seed);
        b = $random(seed);
        send(ex_op_pkg::OP_MUL, a, b, '0, '0);
        while (outstanding != 0) begin
            assert (mult_busy)
                else stop_run($sformatf("Mismatch at %0t: mult_busy low before broadcast", $time));
            @(negedge clock);
        end

        send_and_drain(ex_op_pkg::OP_SW, 32'd10, 32'hcafe_f00d, 32'd4, '0);
        send_and_drain(ex_op_pkg::OP_LW, 32'd6, '0, 32'd8, '0);

        // all three units finish in the same cycle
        exact_latency = 1'b0;
        a     = $random(seed);
        b     = $random(seed);
        t_mul = next_tag;
        send(ex_op_pkg::OP_MUL, a, b, '0, '0);
        repeat (30) @(negedge clock);
        t_mem = next_tag;
        send(ex_op_pkg::OP_LW, 32'd14, '0, '0, '0);
        t_alu = next_tag;
        send(ex_op_pkg::OP_XOR, a, b, '0, '0);
        wait_idle();
        assert (bcast_cycle[t_mul] == bcast_cycle[t_alu] + 1
                && bcast_cycle[t_mem] == bcast_cycle[t_alu] + 2)
            else stop_run($sformatf("Mismatch at %0t: contended results out of order", $time));

        // random mix issued only into free units and free tags
        sent = 0;
        while (sent < RANDOM_OPS) begin
            pick = $random(seed);
            op   = ex_op_pkg::ex_op_e'(4'(pick[15:0] % 11));
            a    = $random(seed);
            b    = pick[16] ? a : $random(seed);
            if (pick[19:17] != 3'd0 && !unit_busy(unit_of(op)) && !pending[next_tag]) begin
                send(op, a, b, $random(seed), $random(seed));
                sent = sent + 1;
            end else begin
                @(negedge clock);
            end
        end
        wait_idle();
        @(negedge clock);

        if (dut0.chk0.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
ex_op_pkg.sv
ex_result_pkg.sv
fu_if.sv
alu_fu.sv
mult_ctrl.sv
step_timer.sv
mult_fu.sv
mem_fu.sv
ex.sv
ex_checker.sv
ex_tb.sv
